//--- fetch_trace_pkg.sv
package fetch_trace_pkg;

  // memory word and address widths
  typedef logic [15:0] word_t;  // one program word
  typedef logic [5:0]  addr_t;  // word address, logical or physical
  typedef logic [2:0]  seg_t;   // physical segment index
  typedef logic [2:0]  page_t;  // logical page number

  // geometry
  localparam int PAGE_WORDS = 8;                    // addr[5:3] page, addr[2:0] offset
  localparam int OFF_BITS   = $clog2(PAGE_WORDS);
  localparam int NUM_SEGS   = 8;
  localparam int MEM_WORDS  = 64;

  // next segment per segment, self pointer ends the chain
  // 0 -> 5 -> 2 -> 1 -> 1
  localparam seg_t SEG_CHAIN [NUM_SEGS] = '{
    3'd5, 3'd1, 3'd1, 3'd3, 3'd4, 3'd2, 3'd6, 3'd7
  };

  // logical page held by each segment
  localparam page_t SEG_PAGE [NUM_SEGS] = '{
    3'd0, 3'd1, 3'd2, 3'd0, 3'd0, 3'd3, 3'd0, 3'd0
  };

  localparam logic [7:0] OPC_HALT = 8'h0F;   // ends a run

  localparam string MEM_FILE = "program.hex";  // physical image, one word per line

endpackage

//--- uart_pkg.sv
package uart_pkg;

  typedef logic [7:0] char_t;  // one serial character

  localparam int CLK_PER_BIT = 8;  // clocks per serial bit
  localparam int CYC_W       = $clog2(CLK_PER_BIT);
  localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(CLK_PER_BIT - 1);

  localparam int QUEUE_DEPTH = 16;  // trace bytes buffered ahead of the serializer
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam logic [QPTR_W:0] QUEUE_FULL = (QPTR_W + 1)'(QUEUE_DEPTH);

  localparam char_t CHAR_START = "S";  // run started
  localparam char_t CHAR_FAULT = "E";  // unmapped page

endpackage

//--- word_fetch_if.sv
`timescale 1ns/1ns

// logical word read, fetcher to paged memory
interface word_fetch_if;
  import fetch_trace_pkg::*;

  logic  req;    // held until ack or fault
  addr_t addr;   // logical word address, stable under req
  logic  ack;    // one cycle, data valid
  word_t data;
  logic  fault;  // one cycle, page not mapped

  modport fetcher (output req, addr, input ack, data, fault);
  modport memory  (input req, addr, output ack, data, fault);

endinterface

//--- pc_fetcher.sv
`timescale 1ns/1ns

module pc_fetcher (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  fetch_trace_pkg::addr_t start_addr,
  output logic                   busy,
  word_fetch_if.fetcher          mem,
  output logic                   valid,
  output uart_pkg::char_t        data,
  input  logic                   ready
);
  import fetch_trace_pkg::*;
  import uart_pkg::*;

  typedef enum logic [2:0] {
    idle,
    send_start,
    read_op,
    send_op,
    read_arg,
    send_arg,
    send_fault
  } state_t;

  state_t     state;
  addr_t      pc;    // next logical word
  logic [7:0] op_q;  // opcode of the current instruction

  assign mem.addr = pc;  // pc only moves after ack, so addr holds under req

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= idle;
      busy    <= 1'b0;
      valid   <= 1'b0;
      mem.req <= 1'b0;
    end else begin
      case (state)
        idle: if (run) begin  // run ignored while busy
          pc    <= start_addr;
          busy  <= 1'b1;
          valid <= 1'b1;
          data  <= CHAR_START;
          state <= send_start;
        end
        send_start: if (valid && ready) begin
          valid   <= 1'b0;
          mem.req <= 1'b1;  // first word of the instruction
          state   <= read_op;
        end
        read_op: begin
          if (mem.ack) begin
            mem.req <= 1'b0;
            pc      <= pc + 1'b1;
            op_q    <= mem.data[15:8];
            data    <= mem.data[15:8];  // opcode byte
            valid   <= 1'b1;
            state   <= send_op;
          end else if (mem.fault) begin
            mem.req <= 1'b0;
            data    <= CHAR_FAULT;
            valid   <= 1'b1;
            state   <= send_fault;
          end
        end
        send_op: if (valid && ready) begin
          valid   <= 1'b0;
          mem.req <= 1'b1;  // argument word, opcode already queued
          state   <= read_arg;
        end
        read_arg: begin
          if (mem.ack) begin
            mem.req <= 1'b0;
            pc      <= pc + 1'b1;
            data    <= mem.data[7:0];  // low byte of the argument
            valid   <= 1'b1;
            state   <= send_arg;
          end else if (mem.fault) begin
            mem.req <= 1'b0;
            data    <= CHAR_FAULT;
            valid   <= 1'b1;
            state   <= send_fault;
          end
        end
        send_arg: if (valid && ready) begin
          valid <= 1'b0;
          if (op_q == OPC_HALT) begin
            busy  <= 1'b0;  // halt pair queued, run done
            state <= idle;
          end else begin
            mem.req <= 1'b1;
            state   <= read_op;
          end
        end
        send_fault: if (valid && ready) begin
          valid <= 1'b0;
          busy  <= 1'b0;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- paged_memory.sv
`timescale 1ns/1ns

module paged_memory (
  input  logic         clk,
  input  logic         rst_n,
  word_fetch_if.memory mem
);
  import fetch_trace_pkg::*;

  typedef enum logic [1:0] {
    idle,
    walk,
    read
  } state_t;

  state_t              state;
  page_t               page_q;  // page being searched
  logic [OFF_BITS-1:0] off_q;   // word within the page
  seg_t                seg_q;   // current chain position
  word_t               mem_array [MEM_WORDS];

  initial $readmemh(MEM_FILE, mem_array);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= idle;
      mem.ack   <= 1'b0;
      mem.fault <= 1'b0;
    end else begin
      mem.ack   <= 1'b0;  // both are single cycle pulses
      mem.fault <= 1'b0;
      case (state)
        // req is still high in the pulse cycle, so skip it
        idle: if (mem.req && !mem.ack && !mem.fault) begin
          page_q <= mem.addr[$bits(addr_t)-1:OFF_BITS];
          off_q  <= mem.addr[OFF_BITS-1:0];
          if (mem.addr[$bits(addr_t)-1:OFF_BITS] == '0) begin
            seg_q <= '0;  // page 0 lives in segment 0
            state <= read;
          end else begin
            seg_q <= SEG_CHAIN[0];  // walk starts after segment 0
            state <= walk;
          end
        end
        walk: begin
          if (SEG_PAGE[seg_q] == page_q) begin
            state <= read;
          end else if (SEG_CHAIN[seg_q] == seg_q) begin
            mem.fault <= 1'b1;  // end of chain, no match
            state     <= idle;
          end else begin
            seg_q <= SEG_CHAIN[seg_q];  // one step per clock
          end
        end
        read: begin
          mem.data <= mem_array[{seg_q, off_q}];  // physical = segment : offset
          mem.ack  <= 1'b1;
          state    <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- trace_queue.sv
`timescale 1ns/1ns

module trace_queue (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid,
  input  uart_pkg::char_t data,
  output logic            ready,
  output logic            tx_valid,
  output uart_pkg::char_t tx_data,
  input  logic            tx_busy
);
  import uart_pkg::*;

  char_t             fifo [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QPTR_W:0]   count;  // one bit wider, holds full
  logic              push;
  logic              pop;

  assign ready    = (count != QUEUE_FULL);  // low when full, fetcher holds its byte
  assign tx_valid = (count != '0);
  assign tx_data  = fifo[rd_ptr];
  assign push     = valid && ready;
  assign pop      = tx_valid && !tx_busy;  // serializer latches at this edge

  always_ff @(posedge clk) begin
    if (push) fifo[wr_ptr] <= data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tx_valid,
  input  uart_pkg::char_t tx_data,
  output logic            tx_busy,
  output logic            tx
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } state_t;

  state_t           state;
  logic [CYC_W-1:0] cyc_cnt;  // clocks within the current bit
  logic [2:0]       bit_cnt;  // data bit index
  char_t            shreg;    // lsb goes out first
  logic             bit_end;

  assign bit_end = (cyc_cnt == CYC_LAST);
  assign tx_busy = (state != idle);  // high for the whole frame

  always_comb begin
    case (state)
      start:   tx = 1'b0;
      data:    tx = shreg[0];
      default: tx = 1'b1;  // idle and stop
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= idle;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
      case (state)
        idle: begin
          cyc_cnt <= '0;
          if (tx_valid) begin
            shreg <= tx_data;  // pop edge in the queue
            state <= start;
          end
        end
        start: if (bit_end) begin
          bit_cnt <= '0;
          state   <= data;
        end
        data: if (bit_end) begin
          shreg   <= shreg >> 1;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= stop;  // 8 bits out
        end
        stop: if (bit_end) state <= idle;
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- fetch_trace_top.sv
`timescale 1ns/1ns

module fetch_trace_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  fetch_trace_pkg::addr_t start_addr,
  output logic                   tx,
  output logic                   busy
);
  import uart_pkg::*;

  logic  byte_valid;  // fetcher to queue
  char_t byte_data;
  logic  byte_ready;
  logic  tx_valid;    // queue to serializer
  char_t tx_data;
  logic  tx_busy;

  word_fetch_if fetch_bus ();

  pc_fetcher pc_fetcher_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .start_addr (start_addr),
    .busy       (busy),
    .mem        (fetch_bus.fetcher),
    .valid      (byte_valid),
    .data       (byte_data),
    .ready      (byte_ready)
  );

  paged_memory paged_memory_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (fetch_bus.memory)
  );

  trace_queue trace_queue_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid    (byte_valid),
    .data     (byte_data),
    .ready    (byte_ready),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy)
  );

  uart_tx uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule

//--- tb_fetch_trace.sv
`timescale 1ns/1ns

module tb_fetch_trace;
  import fetch_trace_pkg::*;
  import uart_pkg::*;

  localparam int CLK_HALF    = 20;  // 40 ns period
  localparam int RESET_CYC   = 10;
  localparam int FRAME_CYC   = 10 * CLK_PER_BIT;
  // two runs of up to 20 chars at about 81 clocks each plus fetch, reset and margin
  localparam int TIMEOUT_CYC = 12000;

  logic  clk;
  logic  rst_n;
  logic  run;
  addr_t start_addr;
  logic  tx;
  logic  busy;

  word_t model_mem [MEM_WORDS];  // own copy of the image
  char_t exp_q [$];              // expected characters of both runs in order
  int    rx_count = 0;
  int    cycles   = 0;
  logic  saw_full = 1'b0;        // queue pushed back on the fetcher at least once

  fetch_trace_top fetch_trace_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .start_addr (start_addr),
    .tx         (tx),
    .busy       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // logical to physical by the page chain with -1 on a fault
  function automatic int translate(input addr_t laddr);
    page_t page;
    seg_t  seg;
    page = laddr[5:3];
    if (page == 3'd0) return int'(laddr);  // page 0 is segment 0
    seg = SEG_CHAIN[0];
    repeat (NUM_SEGS) begin
      if (SEG_PAGE[seg] == page) return int'(seg) * PAGE_WORDS + int'(laddr) % PAGE_WORDS;
      if (SEG_CHAIN[seg] == seg) return -1;  // self loop ends the chain
      seg = SEG_CHAIN[seg];
    end
    return -1;
  endfunction

  // appends the characters one run should produce
  task automatic add_run(input addr_t start);
    addr_t pc;
    int    pa;
    int    pb;
    char_t op;
    logic  done;
    exp_q.push_back(CHAR_START);
    pc   = start;
    done = 1'b0;
    while (!done) begin
      pa = translate(pc);
      if (pa < 0) begin
        exp_q.push_back(CHAR_FAULT);
        done = 1'b1;
      end else begin
        op = model_mem[pa][15:8];
        exp_q.push_back(op);  // opcode queued before the argument read
        pb = translate(pc + 6'd1);
        if (pb < 0) begin
          exp_q.push_back(CHAR_FAULT);
          done = 1'b1;
        end else begin
          exp_q.push_back(model_mem[pb][7:0]);
          done = (op == OPC_HALT);  // halt pair is the last one
          pc   = pc + 6'd2;
        end
      end
    end
  endtask

  task automatic check_char(input char_t got);
    assert (rx_count < exp_q.size())
      else report_failure("an extra character arrived after the expected list");
    assert (got == exp_q[rx_count])
      else report_failure($sformatf("FAIL @ %0t ns: char %0d expected %h, received %h",
                                    $time, rx_count, exp_q[rx_count], got));
    rx_count++;
  endtask

  task automatic start_run(input addr_t addr);
    @(posedge clk);
    run        <= 1'b1;
    start_addr <= addr;
    @(posedge clk);
    run <= 1'b0;
    @(negedge clk);
    assert (busy) else report_failure("busy did not rise after the run pulse");
  endtask

  task automatic wait_idle();
    while (busy) @(negedge clk);  // busy falls once queuing ends
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) report_failure("timeout: characters missing");
  end

  // back-pressure seen when the queue drops ready
  always @(negedge clk) begin
    if (rst_n && !fetch_trace_top_inst.byte_ready) saw_full <= 1'b1;
  end

  // 8N1 decoder sampling at mid-bit
  initial begin : serial_decoder
    char_t rx;
    forever begin
      @(negedge clk);
      if (rst_n && tx == 1'b0) begin
        repeat (CLK_PER_BIT / 2) @(negedge clk);
        assert (tx == 1'b0) else report_failure("start bit ended before mid-bit");
        for (int i = 0; i < 8; i++) begin
          repeat (CLK_PER_BIT) @(negedge clk);
          rx[i] = tx;  // lsb first
        end
        repeat (CLK_PER_BIT) @(negedge clk);
        assert (tx == 1'b1) else report_failure("stop bit missing");
        check_char(rx);
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    start_addr = '0;
    $readmemh(MEM_FILE, model_mem);
    add_run(6'd8);   // pages 1 and 2 with the halt at 22
    add_run(6'd24);  // page 3 then a fault at 32
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) begin  // quiet until run
      @(negedge clk);
      assert (tx == 1'b1 && !busy) else report_failure("tx or busy active before any run");
    end
    start_run(6'd8);
    wait_idle();
    start_run(6'd24);  // run 1 still draining so the queue fills
    wait_idle();
    while (rx_count < exp_q.size()) @(negedge clk);
    repeat (3 * FRAME_CYC) begin
      @(negedge clk);
      assert (tx == 1'b1) else report_failure("line left idle state after the last character");
    end
    assert (saw_full) else report_failure("queue never applied back-pressure");
    if (!busy) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_failure("busy rose again after the last run");
    end
  end

endmodule

//--- program.hex
// physical word image, one 16-bit word per line, line n is physical address n
// unused words hold DA00 plus their address
DA00
DA01
DA02
DA03
DA04
DA05
DA06
DA07
1203
0A41
2104
0B42
3305
0C43
4406
0D44
5507
0E45
6608
0F46
7709
1047
0F0A
1148
DA18
DA19
DA1A
DA1B
DA1C
DA1D
DA1E
DA1F
DA20
DA21
DA22
DA23
DA24
DA25
DA26
DA27
8101
2051
8202
2152
8303
2253
8404
2354
DA30
DA31
DA32
DA33
DA34
DA35
DA36
DA37
DA38
DA39
DA3A
DA3B
DA3C
DA3D
DA3E
DA3F

//--- fetch_trace.f
fetch_trace_pkg.sv
uart_pkg.sv
word_fetch_if.sv
pc_fetcher.sv
paged_memory.sv
trace_queue.sv
uart_tx.sv
fetch_trace_top.sv
tb_fetch_trace.sv

//--- run.sh
#!/bin/sh
# build and run the fetch_trace testbench with Verilator
set -e
verilator --binary --assert --top-module tb_fetch_trace -f fetch_trace.f -o sim_fetch_trace
out=$(./obj_dir/sim_fetch_trace) || true
echo "$out"
echo "$out" | grep -q "^TEST PASS$"
